// File: design/mmu_sv39_pkg.sv
package mmu_sv39_pkg;

    // only the bare and sv39 modes are told apart here.
    localparam logic [3:0] SATP_MODE_BARE = 4'h0;
    localparam logic [1:0] PRIV_S = 2'b01;
    localparam int LEVELS = 3;

    typedef logic [1:0] priv_t;

    typedef struct packed {
        logic [24:0] sign;   // copies of bit 38.
        logic [8:0]  vpn2;
        logic [8:0]  vpn1;
        logic [8:0]  vpn0;
        logic [11:0] offset;
    } va_t;

    typedef struct packed {
        logic [9:0]  reserved;
        logic [43:0] ppn;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    // one response word, raw data for a translated read or a PTE during a walk.
    typedef union packed {
        logic [63:0] data;
        pte_t        pte;
    } pte_word_u;

    typedef struct packed {
        logic [3:0]  mode;
        logic [15:0] asid;
        logic [43:0] ppn;
    } satp_t;

    typedef struct packed {
        logic [26:0] vpn;
        logic [43:0] ppn;
    } tlb_entry_t;

    typedef enum logic [1:0] {PTE_POINTER, PTE_LEAF, PTE_FAULT} pte_kind_e;

endpackage

// File: design/tl_bus_pkg.sv
package tl_bus_pkg;

    // channel A opcode for a read.
    localparam logic [2:0] TL_GET = 3'd4;

    // size is log2 of the byte count, so 3 means eight bytes.
    localparam logic [2:0] WORD_SIZE = 3'd3;

    typedef struct packed {
        logic [2:0]  opcode;
        logic [2:0]  size;
        logic [3:0]  source;
        logic [63:0] address;
        logic [7:0]  mask;
        logic [63:0] data;
    } tl_a_t;

    // the response channel has no ready, every beat is taken when it arrives.
    typedef struct packed {
        logic [2:0]  opcode;
        logic [2:0]  size;
        logic [3:0]  source;
        logic        denied;
        logic [63:0] data;
    } tl_d_t;

endpackage

// File: design/pte_check.sv
`timescale 1ns/100ps

module pte_check (
    input  mmu_sv39_pkg::pte_t      pte,
    input  logic [1:0]              level,
    input  mmu_sv39_pkg::va_t       va,
    output mmu_sv39_pkg::pte_kind_e pte_kind,
    output logic [63:0]             next_table_addr,
    output logic [63:0]             leaf_paddr,
    output logic [43:0]             leaf_ppn
);
    import mmu_sv39_pkg::*;

    logic       is_pointer;
    logic       is_leaf;
    logic [8:0] next_index;

    // a valid entry with no permission bits points at the next table.
    assign is_pointer = pte.v & ~(pte.r | pte.w | pte.x);

    // writable without readable is reserved, so it lands in the fault case.
    assign is_leaf = pte.v & (pte.r | (pte.x & ~pte.w));

    always_comb begin
        if (is_leaf) begin
            pte_kind = PTE_LEAF;
        end else if (is_pointer && level != 2'd0) begin
            pte_kind = PTE_POINTER;
        end else begin
            pte_kind = PTE_FAULT;   // includes a pointer found in the last table.
        end
    end

    // the index into the next table comes from the level below this one.
    always_comb begin
        case (level)
            2'd2:    next_index = va.vpn1;
            default: next_index = va.vpn0;
        endcase
    end

    assign next_table_addr = {8'b0, pte.ppn, next_index, 3'b000};

    // superpages fill their low PPN bits from the virtual page number.
    always_comb begin
        case (level)
            2'd2:    leaf_ppn = {pte.ppn[43:18], va.vpn1, va.vpn0};
            2'd1:    leaf_ppn = {pte.ppn[43:9], va.vpn0};
            default: leaf_ppn = pte.ppn;
        endcase
    end

    assign leaf_paddr = {8'b0, leaf_ppn, va.offset};

endmodule

// File: design/page_walker.sv
`timescale 1ns/100ps

module page_walker #(
    parameter logic [3:0] WALK_SOURCE = 4'hf
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mmu_sv39_pkg::satp_t      satp,
    input  mmu_sv39_pkg::priv_t      priv,
    input  tl_bus_pkg::tl_a_t        virt_a,
    input  logic                     virt_a_valid,
    output logic                     virt_a_ready,
    input  logic                     tlb_hit,
    input  logic [43:0]              tlb_ppn,
    output logic [26:0]              tlb_vpn,
    output tl_bus_pkg::tl_a_t        walk_a,
    output logic                     walk_a_valid,
    input  logic                     walk_a_ready,
    input  mmu_sv39_pkg::pte_word_u  pte_word,
    input  logic                     pte_valid,
    output mmu_sv39_pkg::pte_t       pte,
    output logic [1:0]               level,
    input  mmu_sv39_pkg::pte_kind_e  pte_kind,
    input  logic [63:0]              next_table_addr,
    input  logic [63:0]              leaf_paddr,
    input  logic [43:0]              leaf_ppn,
    output logic                     tlb_update,
    output mmu_sv39_pkg::tlb_entry_t tlb_entry,
    output logic                     page_fault,
    output logic [63:0]              tval,
    output logic                     paging
);
    import mmu_sv39_pkg::*;
    import tl_bus_pkg::*;

    localparam logic [1:0] TOP_LEVEL = 2'(LEVELS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_TABLE_READ,
        S_TABLE_CHECK,
        S_XLATE,
        S_FAULT
    } state_e;

    state_e    state;
    tl_a_t     req_q;
    pte_word_u pte_q;
    va_t       va_in;
    logic      start;
    logic      xfer;

    assign paging = (priv == PRIV_S) && (satp.mode != SATP_MODE_BARE);
    assign va_in = virt_a.address;
    assign pte = pte_q.pte;
    assign start = (state == S_IDLE) && paging && virt_a_valid;
    assign xfer = walk_a_valid & walk_a_ready;

    // the TLB is looked up with the live request, later with the saved copy.
    assign tlb_vpn = (state == S_IDLE) ? {va_in.vpn2, va_in.vpn1, va_in.vpn0}
                                       : req_q.address[38:12];

    // with paging off the core sees the physical ready directly.
    assign virt_a_ready = paging ? ((state == S_XLATE) && xfer) : walk_a_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            level <= TOP_LEVEL;
            walk_a_valid <= 1'b0;
            tlb_update <= 1'b0;
            page_fault <= 1'b0;
        end else begin
            tlb_update <= 1'b0;
            page_fault <= 1'b0;
            if (xfer) begin
                walk_a_valid <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        walk_a_valid <= 1'b1;
                        state <= tlb_hit ? S_XLATE : S_TABLE_READ;
                    end
                end
                S_TABLE_READ: begin
                    if (pte_valid) begin
                        state <= S_TABLE_CHECK;
                    end
                end
                S_TABLE_CHECK: begin
                    case (pte_kind)
                        PTE_POINTER: begin
                            walk_a_valid <= 1'b1;
                            level <= level - 2'd1;
                            state <= S_TABLE_READ;
                        end
                        PTE_LEAF: begin
                            walk_a_valid <= 1'b1;
                            tlb_update <= 1'b1;
                            level <= TOP_LEVEL;
                            state <= S_XLATE;
                        end
                        default: begin
                            page_fault <= 1'b1;
                            level <= TOP_LEVEL;
                            state <= S_FAULT;
                        end
                    endcase
                end
                S_XLATE: begin
                    // the answer itself goes to the core, here it only ends the request.
                    if (pte_valid) begin
                        state <= S_IDLE;
                    end
                end
                S_FAULT: state <= S_IDLE;   // page_fault is high for this one cycle.
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_q <= virt_a;
            if (tlb_hit) begin
                walk_a <= virt_a;
                walk_a.address <= {8'b0, tlb_ppn, va_in.offset};
            end else begin
                walk_a <= '{opcode:  TL_GET,
                            size:    WORD_SIZE,
                            source:  WALK_SOURCE,
                            address: {8'b0, satp.ppn, va_in.vpn2, 3'b000},
                            mask:    8'hff,
                            data:    64'b0};
            end
        end
        if (state == S_TABLE_READ && pte_valid) begin
            pte_q <= pte_word;
        end
        if (state == S_TABLE_CHECK) begin
            case (pte_kind)
                PTE_POINTER: walk_a.address <= next_table_addr;
                PTE_LEAF: begin
                    walk_a <= req_q;
                    walk_a.address <= leaf_paddr;
                    tlb_entry <= '{vpn: req_q.address[38:12], ppn: leaf_ppn};
                end
                default: tval <= req_q.address;
            endcase
        end
    end

endmodule

// File: design/bus_bypass.sv
`timescale 1ns/100ps

module bus_bypass #(
    parameter logic [3:0] WALK_SOURCE = 4'hf
) (
    input  logic                    paging,
    input  tl_bus_pkg::tl_a_t       virt_a,
    input  logic                    virt_a_valid,
    input  tl_bus_pkg::tl_a_t       walk_a,
    input  logic                    walk_a_valid,
    output logic                    walk_a_ready,
    output tl_bus_pkg::tl_a_t       phy_a,
    output logic                    phy_a_valid,
    input  logic                    phy_a_ready,
    input  tl_bus_pkg::tl_d_t       phy_d,
    input  logic                    phy_d_valid,
    output tl_bus_pkg::tl_d_t       virt_d,
    output logic                    virt_d_valid,
    output mmu_sv39_pkg::pte_word_u pte_word,
    output logic                    pte_valid
);

    logic walk_resp;

    // a response tagged with the walker's source is a PTE, never core data.
    assign walk_resp = paging && (phy_d.source == WALK_SOURCE);

    // the walker drives the physical bus whenever translation is active.
    assign phy_a = paging ? walk_a : virt_a;
    assign phy_a_valid = paging ? walk_a_valid : virt_a_valid;
    assign walk_a_ready = phy_a_ready;

    assign virt_d = phy_d;
    assign virt_d_valid = phy_d_valid & ~walk_resp;

    // while paging, the walker sees every response.
    // a PTE during a walk, or the end of the translated read.
    assign pte_word.data = phy_d.data;
    assign pte_valid = phy_d_valid & paging;

endmodule

// File: design/mmu_top.sv
`timescale 1ns/100ps

module mmu_top #(
    parameter logic [3:0] WALK_SOURCE = 4'hf
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mmu_sv39_pkg::priv_t      priv,
    input  mmu_sv39_pkg::satp_t      satp,
    input  tl_bus_pkg::tl_a_t        virt_a,
    input  logic                     virt_a_valid,
    output logic                     virt_a_ready,
    output tl_bus_pkg::tl_d_t        virt_d,
    output logic                     virt_d_valid,
    output tl_bus_pkg::tl_a_t        phy_a,
    output logic                     phy_a_valid,
    input  logic                     phy_a_ready,
    input  tl_bus_pkg::tl_d_t        phy_d,
    input  logic                     phy_d_valid,
    output logic [26:0]              tlb_vpn,
    input  logic                     tlb_hit,
    input  logic [43:0]              tlb_ppn,
    output logic                     tlb_update,
    output mmu_sv39_pkg::tlb_entry_t tlb_entry,
    output logic                     page_fault,
    output logic [63:0]              tval
);
    import mmu_sv39_pkg::*;
    import tl_bus_pkg::*;

    tl_a_t     walk_a;
    logic      walk_a_valid;
    logic      walk_a_ready;
    pte_word_u pte_word;
    logic      pte_valid;
    pte_t      pte;
    logic [1:0] level;
    pte_kind_e pte_kind;
    logic [63:0] next_table_addr;
    logic [63:0] leaf_paddr;
    logic [43:0] leaf_ppn;
    logic      paging;
    va_t       virt_va;

    // the core keeps its request steady until the end, so the live address serves.
    assign virt_va = virt_a.address;

    page_walker #(.WALK_SOURCE(WALK_SOURCE)) u_page_walker (
        .clk(clk), .rst_n(rst_n), .satp(satp), .priv(priv),
        .virt_a(virt_a), .virt_a_valid(virt_a_valid), .virt_a_ready(virt_a_ready),
        .tlb_hit(tlb_hit), .tlb_ppn(tlb_ppn), .tlb_vpn(tlb_vpn),
        .walk_a(walk_a), .walk_a_valid(walk_a_valid), .walk_a_ready(walk_a_ready),
        .pte_word(pte_word), .pte_valid(pte_valid), .pte(pte), .level(level),
        .pte_kind(pte_kind), .next_table_addr(next_table_addr),
        .leaf_paddr(leaf_paddr), .leaf_ppn(leaf_ppn),
        .tlb_update(tlb_update), .tlb_entry(tlb_entry),
        .page_fault(page_fault), .tval(tval), .paging(paging)
    );

    pte_check u_pte_check (
        .pte(pte), .level(level), .va(virt_va), .pte_kind(pte_kind),
        .next_table_addr(next_table_addr), .leaf_paddr(leaf_paddr), .leaf_ppn(leaf_ppn)
    );

    bus_bypass #(.WALK_SOURCE(WALK_SOURCE)) u_bus_bypass (
        .paging(paging), .virt_a(virt_a), .virt_a_valid(virt_a_valid),
        .walk_a(walk_a), .walk_a_valid(walk_a_valid), .walk_a_ready(walk_a_ready),
        .phy_a(phy_a), .phy_a_valid(phy_a_valid), .phy_a_ready(phy_a_ready),
        .phy_d(phy_d), .phy_d_valid(phy_d_valid),
        .virt_d(virt_d), .virt_d_valid(virt_d_valid),
        .pte_word(pte_word), .pte_valid(pte_valid)
    );

endmodule

// File: tests/tb_mmu_models.sv
`timescale 1ns/100ps

module tb_mem_model (
    input  logic              clk,
    input  logic              rst_n,
    input  tl_bus_pkg::tl_a_t phy_a,
    input  logic              phy_a_valid,
    output logic              phy_a_ready,
    output tl_bus_pkg::tl_d_t phy_d,
    output logic              phy_d_valid
);
    import tl_bus_pkg::*;

    logic [31:0] lfsr_state = 32'hf3faddfc;
    logic [63:0] pte_addr [0:7];
    logic [63:0] pte_data [0:7];
    int          pte_count = 0;
    logic        accept_q = 1'b0;
    tl_a_t       accept_a;
    tl_a_t       held;
    logic        busy = 1'b0;
    int          wait_left = 0;

    // galois form with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    function int take_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit taken.
        end
        return value;
    endfunction

    // every bit of the address shows up in the word.
    function automatic logic [63:0] fill_word(input logic [63:0] addr);
        return {addr[31:0], addr[63:32]} ^ 64'h5a5a_c3c3_0f0f_9696;
    endfunction

    function automatic logic [63:0] read_word(input logic [63:0] addr);
        logic [63:0] word;
        word = fill_word(addr);
        for (int i = 0; i < pte_count; i++) begin
            if (pte_addr[i] == addr) begin
                word = pte_data[i];
            end
        end
        return word;
    endfunction

    task automatic clear_table();
        pte_count = 0;
    endtask

    task automatic set_pte(input logic [63:0] addr, input logic [63:0] data);
        pte_addr[pte_count] = addr;
        pte_data[pte_count] = data;
        pte_count++;
    endtask

    initial begin
        phy_a_ready = 1'b0;
        phy_d = '0;
        phy_d_valid = 1'b0;
    end

    always @(posedge clk) begin
        accept_q <= rst_n && phy_a_valid && phy_a_ready;
        accept_a <= phy_a;
    end

    // the answer comes one to three cycles after the request was taken.
    always @(negedge clk) begin
        phy_d_valid <= 1'b0;
        if (!rst_n) begin
            busy = 1'b0;
            phy_a_ready <= 1'b0;
        end else begin
            if (accept_q) begin
                held = accept_a;
                busy = 1'b1;
                wait_left = 1 + take_bits(2) % 3;
            end
            if (busy) begin
                wait_left = wait_left - 1;
                if (wait_left == 0) begin
                    phy_d <= '{opcode: 3'd1, size: held.size, source: held.source,
                               denied: 1'b0, data: read_word(held.address)};
                    phy_d_valid <= 1'b1;
                    busy = 1'b0;
                end
            end
            phy_a_ready <= (take_bits(2) != 0);   // low in about a quarter of cycles.
        end
    end

endmodule

module tb_tlb_model (
    input  logic                     clk,
    input  logic [26:0]              tlb_vpn,
    output logic                     tlb_hit,
    output logic [43:0]              tlb_ppn,
    input  logic                     tlb_update,
    input  mmu_sv39_pkg::tlb_entry_t tlb_entry
);
    import mmu_sv39_pkg::*;

    tlb_entry_t entries [0:3];
    logic       used [0:3];
    int         next_slot = 0;

    task automatic flush();
        for (int i = 0; i < 4; i++) begin
            used[i] = 1'b0;
        end
    endtask

    task automatic preload(input logic [26:0] vpn, input logic [43:0] ppn);
        entries[next_slot] = '{vpn: vpn, ppn: ppn};
        used[next_slot] = 1'b1;
        next_slot = (next_slot + 1) % 4;   // oldest entry goes first.
    endtask

    initial begin
        flush();
    end

    always @(posedge clk) begin
        if (tlb_update) begin
            preload(tlb_entry.vpn, tlb_entry.ppn);
        end
    end

    always_comb begin
        tlb_hit = 1'b0;
        tlb_ppn = '0;
        for (int i = 0; i < 4; i++) begin
            if (used[i] && entries[i].vpn == tlb_vpn) begin
                tlb_hit = 1'b1;
                tlb_ppn = entries[i].ppn;
            end
        end
    end

endmodule

// File: tests/tb_mmu.sv
`timescale 1ns/100ps

module tb_mmu;
    import mmu_sv39_pkg::*;
    import tl_bus_pkg::*;

    localparam logic [3:0]  WALK_SOURCE = 4'hd;
    localparam logic [3:0]  CORE_SOURCE = 4'h2;
    localparam logic [43:0] ROOT_PPN = 44'h80000;
    localparam logic [9:0]  LEAF_FLAGS = 10'h0cf;
    localparam int          NUM_REQUESTS = 15;
    localparam int          CLK_PERIOD = 20;

    logic        clk;
    logic        rst_n;
    priv_t       priv;
    satp_t       satp;
    tl_a_t       virt_a;
    logic        virt_a_valid;
    logic        virt_a_ready;
    tl_d_t       virt_d;
    logic        virt_d_valid;
    tl_a_t       phy_a;
    logic        phy_a_valid;
    logic        phy_a_ready;
    tl_d_t       phy_d;
    logic        phy_d_valid;
    logic [26:0] tlb_vpn;
    logic        tlb_hit;
    logic [43:0] tlb_ppn;
    logic        tlb_update;
    tlb_entry_t  tlb_entry;
    logic        page_fault;
    logic [63:0] tval;

    // what the request in flight should produce.
    logic [63:0] cur_va = '0;
    logic [63:0] exp_pa = '0;
    logic [43:0] exp_ppn = '0;
    logic [63:0] exp_walk [0:2];
    int          n_walk = 0;
    logic        expect_fault = 1'b0;
    int          walk_seen = 0;
    int          updates_seen = 0;
    int          faults_seen = 0;
    int          resp_seen = 0;
    int          stall_cycles = 0;
    int          error_count = 0;
    int          test_errors = 0;
    int          test_count = 0;
    int          failed_tests = 0;
    logic        paging_exp;
    logic        prev_stalled = 1'b0;
    tl_a_t       prev_a;
    logic [63:0] test_va;

    // supervisor level with a mode other than bare turns translation on.
    assign paging_exp = (priv == 2'b01) && (satp.mode != 4'h0);

    mmu_top #(.WALK_SOURCE(WALK_SOURCE)) u_mmu_top (.*);
    tb_mem_model u_mem (.*);
    tb_tlb_model u_tlb (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (NUM_REQUESTS * 40 + 20));
        $display("timeout: the requests did not complete in the allowed time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [159:0] got,
                                   input logic [159:0] exp);
        error_count++;
        $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("at %0t ns: %s", $time, what);
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (!paging_exp) begin
                assert (phy_a_valid === virt_a_valid && phy_a === virt_a)
                    else report_mismatch("phy_a", {phy_a_valid, phy_a}, {virt_a_valid, virt_a});
                assert (virt_d_valid === phy_d_valid && virt_d === phy_d)
                    else report_mismatch("virt_d", {virt_d_valid, virt_d}, {phy_d_valid, phy_d});
                assert (virt_a_ready === phy_a_ready)
                    else report_mismatch("virt_a_ready", virt_a_ready, phy_a_ready);
            end else if (phy_a_valid && phy_a_ready) begin
                if (phy_a.source == WALK_SOURCE) begin
                    assert (walk_seen < n_walk) else report_failure("unexpected table read");
                    if (walk_seen < n_walk) begin
                        assert (phy_a.address == exp_walk[walk_seen])
                            else report_mismatch("table read address", phy_a.address,
                                                 exp_walk[walk_seen]);
                    end
                    walk_seen++;
                end else begin
                    assert (!expect_fault) else report_failure("translated read after a fault");
                    assert (phy_a.address == exp_pa)
                        else report_mismatch("phy_a.address", phy_a.address, exp_pa);
                end
            end
            // ready belongs to the translated transfer only, never to a table read.
            if (paging_exp) begin
                assert (virt_a_ready === (phy_a_valid && phy_a_ready
                                          && phy_a.source != WALK_SOURCE))
                    else report_mismatch("virt_a_ready", virt_a_ready,
                                         phy_a_valid && phy_a_ready
                                         && phy_a.source != WALK_SOURCE);
            end
            if (virt_d_valid) begin
                assert (virt_d.data == u_mem.fill_word(exp_pa))
                    else report_mismatch("virt_d.data", virt_d.data, u_mem.fill_word(exp_pa));
                resp_seen++;
            end
            if (tlb_update) begin
                assert (tlb_entry == {cur_va[38:12], exp_ppn})
                    else report_mismatch("tlb_entry", tlb_entry, {cur_va[38:12], exp_ppn});
                updates_seen++;
            end
            if (page_fault) begin
                assert (expect_fault) else report_failure("page fault on a good mapping");
                assert (tval == cur_va) else report_mismatch("tval", tval, cur_va);
                faults_seen++;
            end
            // a stalled request must hold still until memory takes it.
            if (prev_stalled) begin
                assert (phy_a_valid && phy_a === prev_a)
                    else report_mismatch("phy_a under back-pressure", {phy_a_valid, phy_a},
                                         {1'b1, prev_a});
            end
            prev_stalled = phy_a_valid && !phy_a_ready;
            if (prev_stalled) begin
                stall_cycles++;
            end
            prev_a = phy_a;
        end
    end

    // tables live at the root page and the pages just above it.
    task automatic build_walk(input logic [63:0] va, input int leaf_level,
                              input logic [43:0] leaf_ppn, input logic [9:0] flags);
        logic [43:0] table_ppn;
        logic [43:0] mask;
        logic [63:0] addr;
        table_ppn = ROOT_PPN;
        n_walk = 0;
        u_mem.clear_table();
        for (int lvl = 2; lvl >= leaf_level; lvl--) begin
            addr = {8'b0, table_ppn, 12'b0} | (((va >> (12 + 9 * lvl)) & 64'h1ff) << 3);
            exp_walk[n_walk] = addr;
            n_walk++;
            if (lvl == leaf_level) begin
                u_mem.set_pte(addr, {10'b0, leaf_ppn, flags});
            end else begin
                table_ppn = ROOT_PPN + 44'(3 - lvl);
                u_mem.set_pte(addr, {10'b0, table_ppn, 10'h001});
            end
        end
        mask = (44'h1 << (9 * leaf_level)) - 44'h1;   // bits a superpage leaves to the VPN.
        exp_ppn = (leaf_ppn & ~mask) | (44'(va >> 12) & mask);
        exp_pa = {8'b0, exp_ppn, va[11:0]};
    endtask

    task automatic run_request(input logic [63:0] va, input logic fault, input int updates);
        logic got_xfer;
        logic finished;
        cur_va = va;
        expect_fault = fault;
        walk_seen = 0;
        updates_seen = 0;
        faults_seen = 0;
        resp_seen = 0;
        virt_a = '{opcode: TL_GET, size: WORD_SIZE, source: CORE_SOURCE, address: va,
                   mask: 8'hff, data: 64'h0};
        virt_a_valid = 1'b1;
        do begin
            @(posedge clk);
            got_xfer = virt_a_ready;
            finished = virt_d_valid || page_fault;
            @(negedge clk);
            if (got_xfer || finished) begin
                virt_a_valid = 1'b0;
            end
        end while (!finished);
        repeat (3) @(negedge clk);   // room for a stray second pulse to show.
        assert (walk_seen == n_walk) else report_mismatch("table reads", walk_seen, n_walk);
        assert (updates_seen == updates) else report_mismatch("tlb_update count", updates_seen,
                                                               updates);
        assert (faults_seen == int'(fault)) else report_mismatch("page_fault count",
                                                                 faults_seen, fault);
        assert (resp_seen == int'(!fault)) else report_mismatch("virt_d_valid count",
                                                                resp_seen, !fault);
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == test_errors) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial begin
        rst_n = 1'b0;
        priv = 2'b11;
        satp = '{mode: 4'h0, asid: 16'h0, ppn: ROOT_PPN};
        virt_a = '0;
        virt_a_valid = 1'b0;
        test_va = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        priv = 2'b01;
        exp_pa = 64'h8000_3a18;
        run_request(64'h8000_3a18, 1'b0, 0);
        satp.mode = 4'h8;
        priv = 2'b00;   // user level never translates.
        exp_pa = 64'h1234_5678_9abc_def0;
        run_request(64'h1234_5678_9abc_def0, 1'b0, 0);
        finish_test("bare mode");

        priv = 2'b01;
        u_mem.clear_table();
        test_va = 64'h0000_0012_3456_7890;
        u_tlb.preload(test_va[38:12], 44'habcd);
        n_walk = 0;
        exp_pa = {8'b0, 44'habcd, 12'h890};
        run_request(test_va, 1'b0, 0);
        exp_pa = {8'b0, 44'habcd, 12'h148};
        run_request({test_va[63:12], 12'h148}, 1'b0, 0);
        finish_test("tlb hit");

        u_tlb.flush();
        test_va = 64'hffff_ffc0_2a31_5678;
        build_walk(test_va, 0, 44'h12345, LEAF_FLAGS);
        run_request(test_va, 1'b0, 1);
        n_walk = 0;   // the second read hits the entry just written.
        exp_pa = {8'b0, exp_ppn, 12'h9a0};
        run_request({test_va[63:12], 12'h9a0}, 1'b0, 0);
        finish_test("4 KiB walk");

        u_tlb.flush();
        test_va = 64'h0000_0023_4567_8abc;
        build_walk(test_va, 2, 44'hc0000, LEAF_FLAGS);
        run_request(test_va, 1'b0, 1);
        test_va = 64'h0000_0011_2233_4455;
        build_walk(test_va, 1, 44'h7400, LEAF_FLAGS);
        run_request(test_va, 1'b0, 1);
        finish_test("superpages");

        u_tlb.flush();
        test_va = 64'h0000_0001_0020_3000;
        build_walk(test_va, 1, 44'h0, 10'h000);   // invalid entry.
        run_request(test_va, 1'b1, 0);
        build_walk(test_va, 0, 44'h5, 10'h005);   // writable but not readable.
        run_request(test_va, 1'b1, 0);
        build_walk(test_va, 0, 44'h5, 10'h001);   // pointer in the last table.
        run_request(test_va, 1'b1, 0);
        finish_test("page fault");

        u_tlb.flush();
        test_va = 64'h0000_0033_0101_2468;
        build_walk(test_va, 0, 44'h22222, LEAF_FLAGS);
        run_request(test_va, 1'b0, 1);
        n_walk = 0;
        run_request(test_va, 1'b0, 0);
        satp.mode = 4'h0;
        exp_pa = test_va;
        run_request(test_va, 1'b0, 0);
        satp.mode = 4'h8;
        test_va = 64'h0000_0005_5aa5_0c30;
        build_walk(test_va, 1, 44'h33e00, LEAF_FLAGS);
        run_request(test_va, 1'b0, 1);
        assert (stall_cycles > 0) else report_failure("memory never held back a request");
        finish_test("back-pressure");

        $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
design/mmu_sv39_pkg.sv
design/tl_bus_pkg.sv
design/pte_check.sv
design/page_walker.sv
design/bus_bypass.sv
design/mmu_top.sv
tests/tb_mmu_models.sv
tests/tb_mmu.sv

// File: Bender.yml
package:
  name: mmu_sv39

sources:
  - files:
      - design/mmu_sv39_pkg.sv
      - design/tl_bus_pkg.sv
      - design/pte_check.sv
      - design/page_walker.sv
      - design/bus_bypass.sv
      - design/mmu_top.sv
  - target: test
    files:
      - tests/tb_mmu_models.sv
      - tests/tb_mmu.sv
